// ==== source/gamePkg.sv ====
// Game screen shared definitions
`default_nettype none

package gamePkg;

    // Pixel colour in RGB 3-3-2 format
    typedef logic [7:0] rgbT;

    // Signed so that offsets left of or above a corner stay meaningful
    typedef logic signed [10:0] coordinateT;

    // Column or row index of a message panel cell
    typedef logic [5:0] cellT;

    // Horizontal phase of the scan line
    typedef enum logic [1:0] {
        active,
        frontPorch,
        syncPulse,
        backPorch
    } scanStateT;

    // 640x480 timing with the standard porches
    localparam int visibleWidth = 640;
    localparam int visibleHeight = 480;
    localparam int hFrontPorch = 16;
    localparam int hSyncWidth = 96;
    localparam int hBackPorch = 48;
    localparam int vFrontPorch = 10;
    localparam int vSyncWidth = 2;
    localparam int vBackPorch = 33;
    localparam int totalWidth = visibleWidth + hFrontPorch + hSyncWidth + hBackPorch;
    localparam int totalHeight = visibleHeight + vFrontPorch + vSyncWidth + vBackPorch;

    localparam rgbT backgroundColor = 8'h00;
    localparam rgbT zoneBorderColor = 8'h80;
    localparam rgbT playerLineColor = 8'h02;
    localparam rgbT gameWonColor = 8'hFF;
    localparam rgbT gameOverColor = 8'h80;

    localparam int movementZoneOffset = 20;
    localparam int statisticsZoneOffset = 20;
    localparam int upperBorder = 20;
    localparam int playerZoneY = 310;

    // Top-left corner of the end-game message panel
    localparam int messageLeft = 63;
    localparam int messageTop = 159;

endpackage

`default_nettype wire

// ==== source/vgaScanner.sv ====
// VGA scan counter
`timescale 1ns/1ps
`default_nettype none

module vgaScanner import gamePkg::*; (
    input  wire logic  clk,
    input  wire logic  resetN,
    output coordinateT pixelX,
    output coordinateT pixelY,
    output logic       hSync,
    output logic       vSync,
    output logic       visible
);

    localparam int hSyncStart = visibleWidth + hFrontPorch;
    localparam int hSyncEnd = hSyncStart + hSyncWidth;
    localparam int vSyncStart = visibleHeight + vFrontPorch;
    localparam int vSyncEnd = vSyncStart + vSyncWidth;

    scanStateT hState;
    scanStateT hStateNext;
    logic      lineEnd;

    assign lineEnd = (pixelX == totalWidth - 1);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixelX <= '0;
            pixelY <= '0;
            hState <= active;
        end else begin
            hState <= hStateNext;
            if (lineEnd) begin
                pixelX <= '0;
                pixelY <= (pixelY == totalHeight - 1) ? '0 : pixelY + coordinateT'(1);
            end else begin
                pixelX <= pixelX + coordinateT'(1);
            end
        end
    end

    // The phase changes on the last pixel of each interval
    always_comb begin
        hStateNext = hState;
        case (hState)
            active:     if (pixelX == visibleWidth - 1) hStateNext = frontPorch;
            frontPorch: if (pixelX == hSyncStart - 1) hStateNext = syncPulse;
            syncPulse:  if (pixelX == hSyncEnd - 1) hStateNext = backPorch;
            backPorch:  if (lineEnd) hStateNext = active;
            default:    hStateNext = active;
        endcase
    end

    // Both sync pulses are active low
    assign hSync = (hState != syncPulse);
    assign vSync = !((pixelY >= vSyncStart) && (pixelY < vSyncEnd));
    assign visible = (hState == active) && (pixelY < visibleHeight);

    // The phase FSM must stay in step with the pixel counter
    activeMatchesCount: assert property (
        @(posedge clk) disable iff (!resetN) (hState == active) == (pixelX < visibleWidth)
    );

endmodule

`default_nettype wire

// ==== source/squareObject.sv ====
// Rectangle hit test
`timescale 1ns/1ps
`default_nettype none

module squareObject import gamePkg::*; #(
    parameter int objectWidth = 64,
    parameter int objectHeight = 16
) (
    input  wire logic       clk,
    input  wire logic       resetN,
    input  wire coordinateT pixelX,
    input  wire coordinateT pixelY,
    input  wire coordinateT topLeftX,
    input  wire coordinateT topLeftY,
    output coordinateT      offsetX,
    output coordinateT      offsetY,
    output logic            insideRect
);

    logic insideX;
    logic insideY;

    // Signed compare keeps corners near the frame edge correct
    assign insideX = (pixelX >= topLeftX) && (pixelX < topLeftX + objectWidth);
    assign insideY = (pixelY >= topLeftY) && (pixelY < topLeftY + objectHeight);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            insideRect <= 1'b0;
            offsetX <= '0;
            offsetY <= '0;
        end else begin
            insideRect <= insideX && insideY;
            offsetX <= pixelX - topLeftX;
            offsetY <= pixelY - topLeftY;
        end
    end

endmodule

`default_nettype wire

// ==== source/endGameBitmap.sv ====
// End-game message glyphs
`timescale 1ns/1ps
`default_nettype none

module endGameBitmap import gamePkg::*; (
    input  wire logic clk,
    input  wire logic resetN,
    input  wire cellT cellX,
    input  wire cellT cellY,
    input  wire logic insideRect,
    input  wire logic gameWon,
    output logic      drawingRequest
);

    localparam int panelRows = 16;

    // Column 0 is the leftmost bit of each row
    localparam logic [0:63] winGlyph [0:15] = '{
        64'hFFFF_FFFF_FFFF_FFFF,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'b1_0000000000_100010_011100_100010_000000_100010_011100_100010_0000000000_1,
        64'b1_0000000000_100010_100010_100010_000000_100010_001000_110010_0000000000_1,
        64'b1_0000000000_010100_100010_100010_000000_100010_001000_101010_0000000000_1,
        64'b1_0000000000_001000_100010_100010_000000_101010_001000_100110_0000000000_1,
        64'b1_0000000000_001000_100010_100010_000000_101010_001000_100010_0000000000_1,
        64'b1_0000000000_001000_100010_100010_000000_110110_001000_100010_0000000000_1,
        64'b1_0000000000_001000_011100_011100_000000_100010_011100_100010_0000000000_1,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'hFFFF_FFFF_FFFF_FFFF
    };

    localparam logic [0:63] loseGlyph [0:15] = '{
        64'hFFFF_FFFF_FFFF_FFFF,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'b1_0000_011100_011100_100010_111110_000000_011100_100010_111110_111100_0000_1,
        64'b1_0000_100010_100010_110110_100000_000000_100010_100010_100000_100010_0000_1,
        64'b1_0000_100000_100010_101010_100000_000000_100010_100010_100000_100010_0000_1,
        64'b1_0000_101110_111110_101010_111100_000000_100010_100010_111100_111100_0000_1,
        64'b1_0000_100010_100010_100010_100000_000000_100010_100010_100000_101000_0000_1,
        64'b1_0000_100010_100010_100010_100000_000000_100010_010100_100000_100100_0000_1,
        64'b1_0000_011100_100010_100010_111110_000000_011100_001000_111110_100010_0000_1,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'h8000_0000_0000_0001,
        64'hFFFF_FFFF_FFFF_FFFF
    };

    logic rowValid;
    logic cellBit;

    assign rowValid = (cellY < panelRows);

    // Only the low row bits address a table, the rest is caught by rowValid
    always_comb begin
        if (gameWon) begin
            cellBit = winGlyph[cellY[3:0]][cellX];
        end else begin
            cellBit = loseGlyph[cellY[3:0]][cellX];
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            drawingRequest <= 1'b0;
        end else begin
            drawingRequest <= insideRect && rowValid && cellBit;
        end
    end

endmodule

`default_nettype wire

// ==== source/background.sv ====
// Background and message panel painter
`timescale 1ns/1ps
`default_nettype none

module background import gamePkg::*; #(
    parameter int pixelWidth = 11,
    parameter int letterShift = 3
) (
    input  wire logic       clk,
    input  wire logic       resetN,
    input  wire coordinateT pixelX,
    input  wire coordinateT pixelY,
    input  wire logic       gameOver,
    input  wire logic       gameWon,
    output rgbT             backgroundRgb,
    output rgbT             endGameRgb,
    output logic [1:0]      bordersDr,
    output logic            endGameDr
);

    localparam int panelColumns = 64;
    localparam int panelRows = 16;
    localparam logic [pixelWidth-1:0] panelWidth = pixelWidth'(panelColumns << letterShift);
    localparam logic [pixelWidth-1:0] panelHeight = pixelWidth'(panelRows << letterShift);

    logic       zoneHit;
    logic       playerLineHit;
    logic [1:0] bordersStage;
    rgbT        colorStage;
    logic       gameOverD;
    logic       gameWonD;
    logic       insideRect;
    coordinateT offsetX;
    coordinateT offsetY;
    cellT       cellX;
    cellT       cellY;

    assign zoneHit = (pixelX == movementZoneOffset)
        || (pixelX == visibleWidth - 1 - movementZoneOffset)
        || (pixelY == upperBorder)
        || (pixelY == visibleHeight - 1 - statisticsZoneOffset);
    assign playerLineHit = (pixelY == playerZoneY);

    // Two stages so the borders line up with the bitmap request
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            bordersStage <= '0;
            colorStage <= backgroundColor;
            bordersDr <= '0;
            backgroundRgb <= backgroundColor;
            gameOverD <= 1'b0;
            gameWonD <= 1'b0;
            endGameRgb <= backgroundColor;
        end else begin
            // The player line wins where it crosses a zone border
            if (playerLineHit) begin
                bordersStage <= 2'b10;
                colorStage <= playerLineColor;
            end else if (zoneHit) begin
                bordersStage <= 2'b01;
                colorStage <= zoneBorderColor;
            end else begin
                bordersStage <= 2'b00;
                colorStage <= backgroundColor;
            end
            bordersDr <= bordersStage;
            backgroundRgb <= colorStage;
            gameOverD <= gameOver;
            gameWonD <= gameWon;
            endGameRgb <= gameWonD ? gameWonColor : gameOverColor;
        end
    end

    squareObject #(
        .objectWidth (panelWidth),
        .objectHeight(panelHeight)
    ) messageSquare (
        .clk       (clk),
        .resetN    (resetN),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .topLeftX  (coordinateT'(messageLeft)),
        .topLeftY  (coordinateT'(messageTop)),
        .offsetX   (offsetX),
        .offsetY   (offsetY),
        .insideRect(insideRect)
    );

    // Each cell covers a square of 2**letterShift pixels
    assign cellX = offsetX[letterShift +: 6];
    assign cellY = offsetY[letterShift +: 6];

    endGameBitmap messageBitmap (
        .clk           (clk),
        .resetN        (resetN),
        .cellX         (cellX),
        .cellY         (cellY),
        .insideRect    (insideRect && gameOverD),
        .gameWon       (gameWonD),
        .drawingRequest(endGameDr)
    );

    // A message pixel belongs to a pixel that was presented with gameOver set
    messageNeedsGameOver: assert property (
        @(posedge clk) disable iff (!resetN) endGameDr |-> $past(gameOver, 2)
    );

endmodule

`default_nettype wire

// ==== source/pixelMixer.sv ====
// Layer priority merge and output register
`timescale 1ns/1ps
`default_nettype none

module pixelMixer import gamePkg::*; (
    input  wire logic       clk,
    input  wire logic       resetN,
    input  wire rgbT        backgroundRgb,
    input  wire rgbT        endGameRgb,
    input  wire logic [1:0] bordersDr,
    input  wire logic       endGameDr,
    input  wire logic       hSync,
    input  wire logic       vSync,
    input  wire logic       visible,
    output rgbT             rgb,
    output logic            hSyncOut,
    output logic            vSyncOut,
    output logic            dataEnable
);

    logic [1:0] hSyncD;
    logic [1:0] vSyncD;
    logic [1:0] visibleD;
    rgbT        merged;

    // End-game message first, then the borders, then plain background
    always_comb begin
        if (endGameDr) begin
            merged = endGameRgb;
        end else if (|bordersDr) begin
            merged = backgroundRgb;
        end else begin
            merged = backgroundColor;
        end
    end

    // Sync and enable come straight from the scanner and need two extra stages
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hSyncD <= 2'b11;
            vSyncD <= 2'b11;
            visibleD <= 2'b00;
            rgb <= '0;
            hSyncOut <= 1'b1;
            vSyncOut <= 1'b1;
            dataEnable <= 1'b0;
        end else begin
            hSyncD <= {hSyncD[0], hSync};
            vSyncD <= {vSyncD[0], vSync};
            visibleD <= {visibleD[0], visible};
            rgb <= visibleD[1] ? merged : '0;
            hSyncOut <= hSyncD[1];
            vSyncOut <= vSyncD[1];
            dataEnable <= visibleD[1];
        end
    end

    // Sync pulses only ever fall inside blanking
    syncInBlanking: assert property (
        @(posedge clk) disable iff (!resetN) (!hSyncOut || !vSyncOut) |-> !dataEnable
    );

endmodule

`default_nettype wire

// ==== source/gameScreen.sv ====
// Game screen top level
`timescale 1ns/1ps
`default_nettype none

module gameScreen import gamePkg::*; #(
    parameter int pixelWidth = 11,
    parameter int letterShift = 3
) (
    input  wire logic clk,
    input  wire logic resetN,
    input  wire logic gameOver,
    input  wire logic gameWon,
    output rgbT       rgb,
    output logic      hSync,
    output logic      vSync,
    output logic      dataEnable
);

    coordinateT pixelX;
    coordinateT pixelY;
    logic       scanHSync;
    logic       scanVSync;
    logic       scanVisible;
    rgbT        backgroundRgb;
    rgbT        endGameRgb;
    logic [1:0] bordersDr;
    logic       endGameDr;

    vgaScanner scanner (
        .clk    (clk),
        .resetN (resetN),
        .pixelX (pixelX),
        .pixelY (pixelY),
        .hSync  (scanHSync),
        .vSync  (scanVSync),
        .visible(scanVisible)
    );

    background #(
        .pixelWidth (pixelWidth),
        .letterShift(letterShift)
    ) screenBackground (
        .clk          (clk),
        .resetN       (resetN),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .gameOver     (gameOver),
        .gameWon      (gameWon),
        .backgroundRgb(backgroundRgb),
        .endGameRgb   (endGameRgb),
        .bordersDr    (bordersDr),
        .endGameDr    (endGameDr)
    );

    pixelMixer mixer (
        .clk          (clk),
        .resetN       (resetN),
        .backgroundRgb(backgroundRgb),
        .endGameRgb   (endGameRgb),
        .bordersDr    (bordersDr),
        .endGameDr    (endGameDr),
        .hSync        (scanHSync),
        .vSync        (scanVSync),
        .visible      (scanVisible),
        .rgb          (rgb),
        .hSyncOut     (hSync),
        .vSyncOut     (vSync),
        .dataEnable   (dataEnable)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod = 50,
    parameter int resetCycles = 4,
    parameter int releaseDelay = 5
) (
    output logic clk,
    output logic resetN
);

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // Release lands just after a rising edge, like every other input change
    initial begin
        resetN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #releaseDelay;
        resetN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/gameScreenTb.sv ====
// Game screen testbench
`timescale 1ns/1ps
`default_nettype none

module gameScreenTb import gamePkg::*; ();

    // Frame geometry for 640x480 with 16/96/48 and 10/2/33 porches
    localparam int lineLength = 800;
    localparam int frameLines = 525;
    localparam int frameSize = lineLength * frameLines;
    localparam int activeWidth = 640;
    localparam int activeHeight = 480;
    localparam int hPulseStart = 656;
    localparam int hPulseCycles = 96;
    localparam int vPulseStart = 490;
    localparam int vPulseLines = 2;
    localparam int pipelineDepth = 3;
    localparam int driveDelay = 5;
    localparam int startupLimit = 50;
    localparam int numEntries = 22;

    typedef struct packed {
        int   x;
        int   y;
        logic gameOver;
        logic gameWon;
        rgbT  expected;
    } entryT;

    logic clk;
    logic resetN;
    logic gameOver = 1'b0;
    logic gameWon = 1'b0;
    rgbT  rgb;
    logic hSync;
    logic vSync;
    logic dataEnable;

    int   pixelIndex = 0;
    int   rgbErrors = 0;
    int   levelErrors = 0;
    int   countErrors = 0;
    int   hLowRun = 0;
    int   vLowRun = 0;
    int   vPulsesSeen = 0;
    int   vPulsesExpected = 0;
    logic timedOut = 1'b0;

    // Entries are in scan order; the last three fall in the following frame
    entryT stimulus [numEntries] = '{
        '{5,   5,   1'b0, 1'b0, 8'h00},
        '{300, 10,  1'b1, 1'b1, 8'h00},
        '{300, 20,  1'b0, 1'b0, 8'h80},
        '{20,  100, 1'b1, 1'b0, 8'h80},
        '{619, 100, 1'b0, 1'b1, 8'h80},
        '{700, 100, 1'b1, 1'b1, 8'h00},
        '{63,  159, 1'b1, 1'b0, 8'h80},
        '{200, 159, 1'b0, 1'b0, 8'h00},
        '{500, 159, 1'b1, 1'b1, 8'hFF},
        '{100, 200, 1'b0, 1'b0, 8'h00},
        '{574, 286, 1'b1, 1'b1, 8'hFF},
        '{20,  310, 1'b0, 1'b0, 8'h02},
        '{300, 310, 1'b1, 1'b1, 8'h02},
        '{619, 310, 1'b0, 1'b0, 8'h02},
        '{300, 400, 1'b1, 1'b0, 8'h00},
        '{20,  459, 1'b0, 1'b0, 8'h80},
        '{300, 459, 1'b1, 1'b1, 8'h80},
        '{100, 470, 1'b0, 1'b0, 8'h00},
        '{300, 500, 1'b1, 1'b1, 8'h00},
        '{63,  159, 1'b0, 1'b1, 8'h00},
        '{574, 286, 1'b1, 1'b0, 8'h80},
        '{10,  300, 1'b0, 1'b0, 8'h00}
    };

    clockGen clocks (
        .clk   (clk),
        .resetN(resetN)
    );

    gameScreen #(
        .pixelWidth (11),
        .letterShift(3)
    ) DUT (
        .clk       (clk),
        .resetN    (resetN),
        .gameOver  (gameOver),
        .gameWon   (gameWon),
        .rgb       (rgb),
        .hSync     (hSync),
        .vSync     (vSync),
        .dataEnable(dataEnable)
    );

    task automatic checkRgb(input string name, input rgbT actual, input rgbT expected);
        if (actual !== expected) begin
            rgbErrors++;
            $display("** Error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            levelErrors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            countErrors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic reportTimeout(input string what);
        timedOut = 1'b1;
        $display("Timeout at %0t while waiting for %s", $time, what);
    endtask

    // Expected sync and enable levels follow from the scan position alone
    task automatic checkTiming();
        int   x;
        int   y;
        logic expEnable;
        logic expHSync;
        logic expVSync;
        x = pixelIndex % lineLength;
        y = pixelIndex / lineLength;
        expEnable = (x < activeWidth) && (y < activeHeight);
        expHSync = !((x >= hPulseStart) && (x < hPulseStart + hPulseCycles));
        expVSync = !((y >= vPulseStart) && (y < vPulseStart + vPulseLines));
        checkLevel("dataEnable", dataEnable, expEnable);
        checkLevel("hSync", hSync, expHSync);
        checkLevel("vSync", vSync, expVSync);
        if (!expEnable) begin
            checkRgb("rgb in blanking", rgb, 8'h00);
        end
        if (!hSync) begin
            hLowRun++;
        end else begin
            if (hLowRun > 0) begin
                checkCount("hSync low cycles", hLowRun, hPulseCycles);
            end
            hLowRun = 0;
        end
        if (!vSync) begin
            vLowRun++;
        end else begin
            if (vLowRun > 0) begin
                checkCount("vSync low cycles", vLowRun, vPulseLines * lineLength);
                vPulsesSeen++;
            end
            vLowRun = 0;
        end
        if (x == 0 && y == vPulseStart + vPulseLines) begin
            vPulsesExpected++;
        end
    endtask

    task automatic advancePixel();
        @(posedge clk);
        #driveDelay;
        pixelIndex = (pixelIndex + 1) % frameSize;
        checkTiming();
    endtask

    task automatic waitForPixel(input int target, input string what);
        int steps;
        steps = 0;
        while (pixelIndex != target && !timedOut) begin
            if (steps > frameSize + 8) begin
                reportTimeout(what);
            end else begin
                advancePixel();
                steps++;
            end
        end
    endtask

    // Output stays black with idle syncs until the pixel at (0,0) comes out
    task automatic waitForFirstPixel();
        int steps;
        steps = 0;
        @(posedge clk);
        #driveDelay;
        while (dataEnable !== 1'b1 && !timedOut) begin
            checkRgb("rgb before first pixel", rgb, 8'h00);
            checkLevel("hSync before first pixel", hSync, 1'b1);
            checkLevel("vSync before first pixel", vSync, 1'b1);
            if (steps >= startupLimit) begin
                reportTimeout("the first visible pixel");
            end else begin
                @(posedge clk);
                #driveDelay;
                steps++;
            end
        end
        if (!timedOut) begin
            pixelIndex = 0;
            checkTiming();
        end
    endtask

    task automatic applyEntry(input entryT entry);
        int target;
        int leadIn;
        target = entry.y * lineLength + entry.x;
        leadIn = (target - pipelineDepth + frameSize) % frameSize;
        waitForPixel(leadIn, "the pixel ahead of the target");
        gameOver = entry.gameOver;
        gameWon = entry.gameWon;
        waitForPixel(target, "the target pixel");
        if (!timedOut) begin
            checkRgb($sformatf("rgb at (%0d,%0d)", entry.x, entry.y), rgb, entry.expected);
        end
    endtask

    initial begin
        waitForFirstPixel();
        for (int i = 0; i < numEntries && !timedOut; i++) begin
            applyEntry(stimulus[i]);
        end
        if (!timedOut) begin
            checkCount("vSync pulses", vPulsesSeen, vPulsesExpected);
            if (vPulsesExpected == 0) begin
                countErrors++;
                $display("The table walk never passed a vertical sync interval");
            end
        end
        $display("Error counts: rgb %0d, level %0d, count %0d",
            rgbErrors, levelErrors, countErrors);
        if (!timedOut && rgbErrors + levelErrors + countErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/gamePkg.sv
source/vgaScanner.sv
source/squareObject.sv
source/endGameBitmap.sv
source/background.sv
source/pixelMixer.sv
source/gameScreen.sv
verification/clockGen.sv
verification/gameScreenTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the game screen testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=simGameScreen
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module gameScreenTb -f sim.f \
    --Mdir "$buildDir" -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Checks failed" "$logFile"; then
    echo "Result: FAIL"
    exit 1
fi
if ! grep -q "All checks passed" "$logFile"; then
    echo "Result: no final verdict in $logFile"
    exit 1
fi
echo "Result: PASS"
exit 0
